// File: verilog/gfx_pkg.sv
/* Shared widths, state and color-depth enums, fragment, vertex and
   framebuffer write structs for the raster back end */
package gfx_pkg;

  // Coordinate, factor, depth and UV width
  localparam int POINT_WIDTH = 16;
  // Framebuffer word address width
  localparam int FB_ADDR_WIDTH = 32;
  // Fixed point 1.0 for the barycentric factors
  localparam logic [POINT_WIDTH:0] FACTOR_ONE = 1 << POINT_WIDTH;
  // Quotient bits per division, one integer bit plus the fraction
  localparam int DIV_STEPS = POINT_WIDTH + 1;

  // Framebuffer pixel formats
  typedef enum logic [1:0] {
    DEPTH_8  = 2'd0,
    DEPTH_16 = 2'd1,
    DEPTH_32 = 2'd2
  } gfx_color_depth_e;

  typedef enum logic [1:0] {
    CUVZ_WAIT,
    CUVZ_PREP,
    CUVZ_WRITE
  } gfx_cuvz_state_e;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } gfx_div_state_e;

  typedef enum logic {
    WR_IDLE,
    WR_BUSY
  } gfx_wr_state_e;

  // One vertex, color in the active depth layout
  typedef struct packed {
    logic [31:0]                   color;
    logic signed [POINT_WIDTH-1:0] z;
    logic [POINT_WIDTH-1:0]        u;
    logic [POINT_WIDTH-1:0]        v;
    logic [7:0]                    a;
  } gfx_vertex_attr_t;

  typedef struct packed {
    gfx_vertex_attr_t vtx0;
    gfx_vertex_attr_t vtx1;
    gfx_vertex_attr_t vtx2;
  } gfx_triangle_t;

  // Incoming fragment, weights not yet normalised
  typedef struct packed {
    logic [POINT_WIDTH-1:0] x;
    logic [POINT_WIDTH-1:0] y;
    logic [POINT_WIDTH-1:0] w0;
    logic [POINT_WIDTH-1:0] w1;
    logic [POINT_WIDTH-1:0] area;
  } gfx_frag_in_t;

  // Interpolated fragment
  typedef struct packed {
    logic [POINT_WIDTH-1:0]        x;
    logic [POINT_WIDTH-1:0]        y;
    logic [31:0]                   color;
    logic signed [POINT_WIDTH-1:0] z;
    logic [POINT_WIDTH-1:0]        u;
    logic [POINT_WIDTH-1:0]        v;
    logic [7:0]                    a;
    logic [POINT_WIDTH-1:0]        bezier0;
    logic [POINT_WIDTH-1:0]        bezier1;
  } gfx_frag_out_t;

  // Framebuffer write request
  typedef struct packed {
    logic [FB_ADDR_WIDTH-1:0] addr;
    logic [31:0]              data;
    logic [3:0]               sel;
  } gfx_mem_wr_t;

endpackage

// File: verilog/gfx_bary_div.sv
/* Barycentric weight normaliser, two restoring dividers in lock step */
module gfx_bary_div import gfx_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   start_i,
  input  gfx_frag_in_t           frag_i,
  output logic                   done_o,
  output logic [POINT_WIDTH-1:0] factor0_o,
  output logic [POINT_WIDTH-1:0] factor1_o,
  output logic [POINT_WIDTH-1:0] x_o,
  output logic [POINT_WIDTH-1:0] y_o
);

  // Result of one restoring step
  typedef struct packed {
    logic                   q;
    logic [POINT_WIDTH:0]   rem;
  } div_step_t;

  gfx_div_state_e         state;
  logic [4:0]             step_cnt;
  // Partial remainders and quotients, bit 16 is the integer bit
  logic [POINT_WIDTH:0]   rem0_q, rem1_q;
  logic [POINT_WIDTH:0]   quot0_q, quot1_q;
  logic [POINT_WIDTH-1:0] area_q;
  logic [POINT_WIDTH-1:0] x_q, y_q;
  div_step_t              step0, step1;

  // Compare, subtract if it fits, then shift in the next zero
  // dividend bit (the low 16 bits of w << 16 are all zero)
  function automatic div_step_t div_step(input logic [POINT_WIDTH:0]   rem,
                                         input logic [POINT_WIDTH-1:0] divisor);
    div_step_t res;
    if (rem >= {1'b0, divisor})
    begin
      res.q   = 1'b1;
      res.rem = (rem - {1'b0, divisor}) << 1;
    end
    else
    begin
      res.q   = 1'b0;
      res.rem = rem << 1;
    end
    return res;
  endfunction

  assign step0 = div_step(rem0_q, area_q);
  assign step1 = div_step(rem1_q, area_q);

  // Control FSM, load on strobe, 17 steps, one done pulse
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state    <= DIV_IDLE;
      step_cnt <= '0;
      done_o   <= 1'b0;
    end
    else
    begin
      case (state)
        DIV_IDLE:
        begin
          step_cnt <= '0;
          if (start_i)
            state <= DIV_RUN;
        end
        DIV_RUN:
        begin
          step_cnt <= step_cnt + 5'd1;
          // Last quotient bit lands together with done
          if (step_cnt == 5'(DIV_STEPS - 1))
          begin
            state  <= DIV_DONE;
            done_o <= 1'b1;
          end
        end
        default:
        begin
          done_o <= 1'b0;
          state  <= DIV_IDLE;
        end
      endcase
    end
  end

  // Datapath, first step yields the integer bit
  always_ff @(posedge clk_i)
  begin
    if (state == DIV_IDLE && start_i)
    begin
      rem0_q  <= {1'b0, frag_i.w0};
      rem1_q  <= {1'b0, frag_i.w1};
      quot0_q <= '0;
      quot1_q <= '0;
      area_q  <= frag_i.area;
      x_q     <= frag_i.x;
      y_q     <= frag_i.y;
    end
    else if (state == DIV_RUN)
    begin
      rem0_q  <= step0.rem;
      rem1_q  <= step1.rem;
      quot0_q <= {quot0_q[POINT_WIDTH-1:0], step0.q};
      quot1_q <= {quot1_q[POINT_WIDTH-1:0], step1.q};
    end
  end

  // Integer bit set means weight >= area, clamp just below 1.0
  assign factor0_o = quot0_q[POINT_WIDTH] ? '1 : quot0_q[POINT_WIDTH-1:0];
  assign factor1_o = quot1_q[POINT_WIDTH] ? '1 : quot1_q[POINT_WIDTH-1:0];
  assign x_o       = x_q;
  assign y_o       = y_q;

endmodule

// File: verilog/gfx_cuvz.sv
/* Barycentric interpolator for color, depth, UV, alpha and
   quadratic Bezier factors */
module gfx_cuvz import gfx_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   write_i,
  input  logic                   ack_i,
  output logic                   ack_o,
  output logic                   write_o,
  input  logic [POINT_WIDTH-1:0] factor0_i,
  input  logic [POINT_WIDTH-1:0] factor1_i,
  input  logic [POINT_WIDTH-1:0] x_i,
  input  logic [POINT_WIDTH-1:0] y_i,
  input  gfx_triangle_t          tri_i,
  input  gfx_color_depth_e       color_depth_i,
  output gfx_frag_out_t          frag_o
);

  // Color channels widened to 8 bits
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  gfx_cuvz_state_e          state;
  // Factors carry one extra bit so 1.0 fits
  logic [POINT_WIDTH:0]     factor0, factor1, factor2;
  logic [POINT_WIDTH:0]     factor_sum;
  logic [POINT_WIDTH-1:0]   x_q, y_q;
  logic [2*POINT_WIDTH-1:0] u_sum, v_sum;
  logic signed [2*POINT_WIDTH-1:0] z_sum;
  logic [POINT_WIDTH+7:0]   a_sum;
  logic [POINT_WIDTH+7:0]   r_sum, g_sum, b_sum;
  logic [POINT_WIDTH:0]     bezier0_full;
  rgb_t                     c0, c1, c2;
  logic [31:0]              color_pack;

  // Split a packed color by depth, gray goes to all three channels
  function automatic rgb_t split_color(input logic [31:0] color,
                                       input gfx_color_depth_e depth);
    rgb_t res;
    case (depth)
      DEPTH_8:  res = '{r: color[7:0], g: color[7:0], b: color[7:0]};
      DEPTH_16: res = '{r: {3'b0, color[15:11]}, g: {2'b0, color[10:5]},
                        b: {3'b0, color[4:0]}};
      default:  res = '{r: color[23:16], g: color[15:8], b: color[7:0]};
    endcase
    return res;
  endfunction

  // Third factor from the first two, clamp at zero
  assign factor_sum = factor0_i + factor1_i;

  // Weighted sums, result kept in the upper half
  assign u_sum = factor0 * tri_i.vtx0.u + factor1 * tri_i.vtx1.u + factor2 * tri_i.vtx2.u;
  assign v_sum = factor0 * tri_i.vtx0.v + factor1 * tri_i.vtx1.v + factor2 * tri_i.vtx2.v;
  assign a_sum = factor0 * tri_i.vtx0.a + factor1 * tri_i.vtx1.a + factor2 * tri_i.vtx2.a;

  // Signed depth, factors get a zero sign bit
  assign z_sum = $signed({1'b0, factor0}) * $signed(tri_i.vtx0.z)
               + $signed({1'b0, factor1}) * $signed(tri_i.vtx1.z)
               + $signed({1'b0, factor2}) * $signed(tri_i.vtx2.z);

  // Loop-Blinn style quadratic curve factors
  assign bezier0_full = (factor1 >> 1) + factor2;

  assign c0 = split_color(tri_i.vtx0.color, color_depth_i);
  assign c1 = split_color(tri_i.vtx1.color, color_depth_i);
  assign c2 = split_color(tri_i.vtx2.color, color_depth_i);

  assign r_sum = factor0 * c0.r + factor1 * c1.r + factor2 * c2.r;
  assign g_sum = factor0 * c0.g + factor1 * c1.g + factor2 * c2.g;
  assign b_sum = factor0 * c0.b + factor1 * c1.b + factor2 * c2.b;

  // Repack into the framebuffer layout
  always_comb
  begin
    case (color_depth_i)
      DEPTH_8:  color_pack = {24'h0, r_sum[POINT_WIDTH+7:POINT_WIDTH]};
      DEPTH_16: color_pack = {16'h0, r_sum[POINT_WIDTH+4:POINT_WIDTH],
                              g_sum[POINT_WIDTH+5:POINT_WIDTH],
                              b_sum[POINT_WIDTH+4:POINT_WIDTH]};
      default:  color_pack = {8'h0, r_sum[POINT_WIDTH+7:POINT_WIDTH],
                              g_sum[POINT_WIDTH+7:POINT_WIDTH],
                              b_sum[POINT_WIDTH+7:POINT_WIDTH]};
    endcase
  end

  // WAIT -> PREP -> WRITE, hold until acked
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state   <= CUVZ_WAIT;
      write_o <= 1'b0;
      ack_o   <= 1'b0;
    end
    else
    begin
      case (state)
        CUVZ_WAIT:
        begin
          ack_o <= 1'b0;
          if (write_i)
            state <= CUVZ_PREP;
        end
        CUVZ_PREP:
        begin
          write_o <= 1'b1;
          state   <= CUVZ_WRITE;
        end
        default:
        begin
          write_o <= 1'b0;
          if (ack_i)
          begin
            ack_o <= 1'b1;
            state <= CUVZ_WAIT;
          end
        end
      endcase
    end
  end

  // Factor capture and result registers
  always_ff @(posedge clk_i)
  begin
    if (state == CUVZ_WAIT && write_i)
    begin
      factor0 <= {1'b0, factor0_i};
      factor1 <= {1'b0, factor1_i};
      factor2 <= (factor_sum >= FACTOR_ONE) ? '0 : FACTOR_ONE - factor_sum;
      x_q     <= x_i;
      y_q     <= y_i;
    end
    if (state == CUVZ_PREP)
    begin
      frag_o.x       <= x_q;
      frag_o.y       <= y_q;
      frag_o.color   <= color_pack;
      frag_o.z       <= z_sum[2*POINT_WIDTH-1:POINT_WIDTH];
      frag_o.u       <= u_sum[2*POINT_WIDTH-1:POINT_WIDTH];
      frag_o.v       <= v_sum[2*POINT_WIDTH-1:POINT_WIDTH];
      frag_o.a       <= a_sum[POINT_WIDTH+7:POINT_WIDTH];
      frag_o.bezier0 <= bezier0_full[POINT_WIDTH-1:0];
      frag_o.bezier1 <= factor2[POINT_WIDTH-1:0];
    end
  end

endmodule

// File: verilog/gfx_fragment_writer.sv
/* Framebuffer writer, address and byte lane generation per color depth */
module gfx_fragment_writer import gfx_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     write_i,
  input  gfx_frag_out_t            frag_i,
  input  gfx_color_depth_e         color_depth_i,
  input  logic [FB_ADDR_WIDTH-1:0] fb_base_i,
  input  logic [POINT_WIDTH-1:0]   fb_width_i,
  input  logic                     mem_ack_i,
  output gfx_mem_wr_t              mem_o,
  output logic                     mem_write_o,
  output logic                     ack_o
);

  gfx_wr_state_e            state;
  logic [FB_ADDR_WIDTH-1:0] pix_idx;
  gfx_mem_wr_t              mem_next;

  // Linear pixel index in the framebuffer
  assign pix_idx = frag_i.y * fb_width_i + frag_i.x;

  // Word address, lanes and replicated data
  always_comb
  begin
    case (color_depth_i)
      DEPTH_8:
      begin
        mem_next.addr = fb_base_i + (pix_idx >> 2);
        mem_next.sel  = 4'b0001 << pix_idx[1:0];
        mem_next.data = {4{frag_i.color[7:0]}};
      end
      DEPTH_16:
      begin
        mem_next.addr = fb_base_i + (pix_idx >> 1);
        // Even x in the low halfword
        mem_next.sel  = frag_i.x[0] ? 4'b1100 : 4'b0011;
        mem_next.data = {2{frag_i.color[15:0]}};
      end
      default:
      begin
        mem_next.addr = fb_base_i + pix_idx;
        mem_next.sel  = 4'b1111;
        mem_next.data = frag_i.color;
      end
    endcase
  end

  // Request held until the memory acks
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state       <= WR_IDLE;
      mem_write_o <= 1'b0;
      ack_o       <= 1'b0;
    end
    else
    begin
      ack_o <= 1'b0;
      case (state)
        WR_IDLE:
          if (write_i)
          begin
            mem_write_o <= 1'b1;
            state       <= WR_BUSY;
          end
        default:
          if (mem_ack_i)
          begin
            mem_write_o <= 1'b0;
            ack_o       <= 1'b1;
            state       <= WR_IDLE;
          end
      endcase
    end
  end

  // Capture once, stable while busy
  always_ff @(posedge clk_i)
  begin
    if (state == WR_IDLE && write_i)
      mem_o <= mem_next;
  end

endmodule

// File: verilog/gfx_raster_backend.sv
/* Raster back end top, divider into interpolator into framebuffer writer */
module gfx_raster_backend import gfx_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     frag_write_i,
  input  gfx_frag_in_t             frag_i,
  input  gfx_triangle_t            tri_i,
  input  gfx_color_depth_e         color_depth_i,
  input  logic [FB_ADDR_WIDTH-1:0] fb_base_i,
  input  logic [POINT_WIDTH-1:0]   fb_width_i,
  input  logic                     mem_ack_i,
  output gfx_mem_wr_t              mem_o,
  output logic                     mem_write_o,
  output gfx_frag_out_t            frag_o,
  output logic                     frag_ack_o
);

  // Divider to interpolator
  logic                   div_done;
  logic [POINT_WIDTH-1:0] factor0, factor1;
  logic [POINT_WIDTH-1:0] div_x, div_y;
  // Interpolator to writer and back
  logic                   cuvz_write;
  logic                   wr_ack;

  gfx_bary_div u_div (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .start_i   (frag_write_i),
    .frag_i    (frag_i),
    .done_o    (div_done),
    .factor0_o (factor0),
    .factor1_o (factor1),
    .x_o       (div_x),
    .y_o       (div_y)
  );

  // Its ack closes the fragment towards the host
  gfx_cuvz u_cuvz (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .write_i       (div_done),
    .ack_i         (wr_ack),
    .ack_o         (frag_ack_o),
    .write_o       (cuvz_write),
    .factor0_i     (factor0),
    .factor1_i     (factor1),
    .x_i           (div_x),
    .y_i           (div_y),
    .tri_i         (tri_i),
    .color_depth_i (color_depth_i),
    .frag_o        (frag_o)
  );

  gfx_fragment_writer u_writer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .write_i       (cuvz_write),
    .frag_i        (frag_o),
    .color_depth_i (color_depth_i),
    .fb_base_i     (fb_base_i),
    .fb_width_i    (fb_width_i),
    .mem_ack_i     (mem_ack_i),
    .mem_o         (mem_o),
    .mem_write_o   (mem_write_o),
    .ack_o         (wr_ack)
  );

endmodule

// File: verification/tb_gfx_checks.svh
/* Model of factors, interpolation, color repack and framebuffer
   addressing, plus typed compare tasks */
`ifndef TB_GFX_CHECKS_SVH
`define TB_GFX_CHECKS_SVH

  // Weight scaled by 1.0 over area, clamped just below 1.0
  function automatic logic [15:0] model_factor(input logic [15:0] w, input logic [15:0] area);
    longint q;
    q = (longint'(w) << 16) / longint'(area);
    return (q > 65535) ? 16'hffff : q[15:0];
  endfunction

  // Third factor, zero once the first two reach 1.0
  function automatic longint model_factor2(input longint f0, input longint f1);
    return (f0 + f1 >= 65536) ? 0 : 65536 - f0 - f1;
  endfunction

  // Weighted sum before the fraction is dropped
  function automatic longint weigh(input longint f0, f1, f2, a0, a1, a2);
    return f0 * a0 + f1 * a1 + f2 * a2;
  endfunction

  // Channel 0 red, 1 green, 2 blue; gray for 8-bit
  function automatic longint channel(input logic [31:0] c, input gfx_color_depth_e d,
                                     input int idx);
    case (d)
      DEPTH_8:  return longint'(c[7:0]);
      DEPTH_16: return (idx == 0) ? longint'(c[15:11]) :
                       (idx == 1) ? longint'(c[10:5]) : longint'(c[4:0]);
      default:  return longint'(c[23-8*idx -: 8]);
    endcase
  endfunction

  function automatic gfx_frag_out_t model_frag(input gfx_frag_in_t f, input gfx_triangle_t t,
                                               input gfx_color_depth_e d);
    gfx_frag_out_t r;
    longint        f0, f1, f2;
    longint        ch [3];
    f0 = model_factor(f.w0, f.area);
    f1 = model_factor(f.w1, f.area);
    f2 = model_factor2(f0, f1);
    for (int i = 0; i < 3; i++)
      ch[i] = weigh(f0, f1, f2, channel(t.vtx0.color, d, i), channel(t.vtx1.color, d, i),
                    channel(t.vtx2.color, d, i)) >> 16;
    case (d)
      DEPTH_8:  r.color = {24'h0, 8'(ch[0])};
      DEPTH_16: r.color = {16'h0, 5'(ch[0]), 6'(ch[1]), 5'(ch[2])};
      default:  r.color = {8'h0, 8'(ch[0]), 8'(ch[1]), 8'(ch[2])};
    endcase
    r.x = f.x;
    r.y = f.y;
    // Signed depth, sign extended before weighting
    r.z = 16'(weigh(f0, f1, f2, longint'($signed(t.vtx0.z)), longint'($signed(t.vtx1.z)),
                    longint'($signed(t.vtx2.z))) >> 16);
    r.u = 16'(weigh(f0, f1, f2, t.vtx0.u, t.vtx1.u, t.vtx2.u) >> 16);
    r.v = 16'(weigh(f0, f1, f2, t.vtx0.v, t.vtx1.v, t.vtx2.v) >> 16);
    r.a = 8'(weigh(f0, f1, f2, t.vtx0.a, t.vtx1.a, t.vtx2.a) >> 16);
    r.bezier0 = 16'((f1 >> 1) + f2);
    r.bezier1 = 16'(f2);
    return r;
  endfunction

  // Word address, lanes and replicated data per depth
  function automatic gfx_mem_wr_t model_mem(input gfx_frag_out_t f, input gfx_color_depth_e d,
                                            input logic [31:0] base, input logic [15:0] width);
    gfx_mem_wr_t m;
    longint      idx;
    idx = longint'(f.y) * longint'(width) + longint'(f.x);
    case (d)
      DEPTH_8:
      begin
        m.addr = 32'(base + (idx >> 2));
        m.sel  = 4'(1 << (idx % 4));
        m.data = {4{f.color[7:0]}};
      end
      DEPTH_16:
      begin
        m.addr = 32'(base + (idx >> 1));
        m.sel  = f.x[0] ? 4'b1100 : 4'b0011;
        m.data = {2{f.color[15:0]}};
      end
      default:
      begin
        m.addr = 32'(base + idx);
        m.sel  = 4'b1111;
        m.data = f.color;
      end
    endcase
    return m;
  endfunction

  task automatic check_frag(input string name, input gfx_frag_out_t got,
                            input gfx_frag_out_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_mem(input string name, input gfx_mem_wr_t got, input gfx_mem_wr_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

`endif

// File: verification/tb_gfx_raster_backend.sv
/* Raster back end testbench, directed fragment tests with LFSR data,
   memory responder, cycle limit and summary */
module tb_gfx_raster_backend import gfx_pkg::*; ();

  localparam int NUM_FRAGS   = 28;
  localparam int MAX_DELAY   = 40;
  // Each fragment takes 21 cycles plus the memory delay
  localparam int CYCLE_LIMIT = NUM_FRAGS * (21 + MAX_DELAY) + 200;

  logic                     clk_i;
  logic                     rst_i;
  logic                     frag_write_i;
  gfx_frag_in_t             frag_i;
  gfx_triangle_t            tri_i;
  gfx_color_depth_e         color_depth_i;
  logic [FB_ADDR_WIDTH-1:0] fb_base_i;
  logic [POINT_WIDTH-1:0]   fb_width_i;
  logic                     mem_ack_i;
  gfx_mem_wr_t              mem_o;
  logic                     mem_write_o;
  gfx_frag_out_t            frag_o;
  logic                     frag_ack_o;

  logic [15:0] lfsr_state;
  int          error_count;
  int          test_count;
  int          test_fail_count;
  int          cycle_count = 0;

  `include "tb_gfx_checks.svh"

  gfx_raster_backend UUT (.*);

  always #50 clk_i = ~clk_i;

  // Cycle limit
  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles, a fragment never completed", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic gfx_vertex_attr_t rand_vertex();
    gfx_vertex_attr_t v;
    v.color = rand_bits(32);
    v.z     = 16'(rand_bits(16));
    v.u     = 16'(rand_bits(16));
    v.v     = 16'(rand_bits(16));
    v.a     = 8'(rand_bits(8));
    return v;
  endfunction

  // Weights inside the triangle so w0 + w1 <= area
  function automatic gfx_frag_in_t rand_frag();
    gfx_frag_in_t f;
    f.x    = 16'(rand_bits(9));
    f.y    = 16'(rand_bits(8));
    f.area = 16'(rand_bits(16));
    if (f.area == 0)
      f.area = 16'd1;
    f.w0 = 16'(rand_bits(16) % (32'(f.area) + 1));
    f.w1 = 16'(rand_bits(16) % (32'(f.area) - 32'(f.w0) + 1));
    return f;
  endfunction

  // Strobe a fragment, ack the write after delay cycles, check everything
  task automatic run_fragment(input gfx_frag_in_t f, input int delay);
    gfx_frag_out_t exp_frag;
    gfx_mem_wr_t   exp_mem;
    int            lat;
    exp_frag     = model_frag(f, tri_i, color_depth_i);
    exp_mem      = model_mem(exp_frag, color_depth_i, fb_base_i, fb_width_i);
    frag_i       = f;
    frag_write_i = 1'b1;
    @(negedge clk_i);
    frag_write_i = 1'b0;
    lat = 0;
    while (!mem_write_o)
    begin
      check_bit("frag_ack_o", frag_ack_o, 1'b0);
      @(negedge clk_i);
      lat++;
    end
    // 17 divider cycles, 2 interpolator, 1 writer
    if (lat != 20)
    begin
      $display("Write request came %0d cycles after the strobe instead of 20", lat);
      error_count++;
    end
    check_mem("mem_o", mem_o, exp_mem);
    // Request must stay put while the memory holds off
    repeat (delay)
    begin
      @(negedge clk_i);
      check_bit("mem_write_o", mem_write_o, 1'b1);
      check_bit("frag_ack_o", frag_ack_o, 1'b0);
      check_mem("mem_o", mem_o, exp_mem);
    end
    mem_ack_i = 1'b1;
    @(negedge clk_i);
    mem_ack_i = 1'b0;
    check_bit("mem_write_o", mem_write_o, 1'b0);
    while (!frag_ack_o)
      @(negedge clk_i);
    check_frag("frag_o", frag_o, exp_frag);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before)
      $display("test %s passed", name);
    else
    begin
      test_fail_count++;
      $display("test %s failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic test_reset();
    int e;
    e = error_count;
    check_bit("frag_ack_o", frag_ack_o, 1'b0);
    check_bit("mem_write_o", mem_write_o, 1'b0);
    color_depth_i = DEPTH_32;
    tri_i         = {rand_vertex(), rand_vertex(), rand_vertex()};
    run_fragment(rand_frag(), 3);
    finish_test("reset", e);
  endtask

  // Full weight on one vertex at a time
  task automatic test_corners();
    int           e;
    gfx_frag_in_t f;
    e     = error_count;
    tri_i = {rand_vertex(), rand_vertex(), rand_vertex()};
    f     = rand_frag();
    f.w0  = f.area;
    f.w1  = '0;
    run_fragment(f, 1);
    f.w0  = '0;
    f.w1  = f.area;
    run_fragment(f, 1);
    f.w1  = '0;
    run_fragment(f, 1);
    finish_test("corners", e);
  endtask

  task automatic test_random_32();
    int e;
    e             = error_count;
    color_depth_i = DEPTH_32;
    for (int i = 0; i < 8; i++)
    begin
      tri_i = {rand_vertex(), rand_vertex(), rand_vertex()};
      run_fragment(rand_frag(), int'(rand_bits(3)));
    end
    finish_test("random_32bit", e);
  endtask

  // RGB565 then grayscale with x stepping through every byte lane
  task automatic test_narrow_depths();
    int           e;
    gfx_frag_in_t f;
    e         = error_count;
    fb_base_i = 32'h0020_0040;
    for (int d = 0; d < 2; d++)
    begin
      color_depth_i = (d == 0) ? DEPTH_16 : DEPTH_8;
      for (int i = 0; i < 6; i++)
      begin
        tri_i    = {rand_vertex(), rand_vertex(), rand_vertex()};
        f        = rand_frag();
        // Line width is a multiple of 4 so the low x bits pick the lane
        f.x[1:0] = 2'(i);
        run_fragment(f, int'(rand_bits(3)));
      end
    end
    finish_test("narrow_depths", e);
  endtask

  // Factor sums at or above 1.0
  task automatic test_saturation();
    int           e;
    gfx_frag_in_t f;
    e             = error_count;
    color_depth_i = DEPTH_32;
    tri_i         = {rand_vertex(), rand_vertex(), rand_vertex()};
    f             = rand_frag();
    f.w0          = f.area;
    f.w1          = f.area;
    run_fragment(f, 2);
    // Exactly 0.5 plus 0.5
    f.area = 16'd4;
    f.w0   = 16'd2;
    f.w1   = 16'd2;
    run_fragment(f, 2);
    f.area = 16'd1000;
    f.w0   = 16'd700;
    f.w1   = 16'd600;
    run_fragment(f, 2);
    finish_test("saturation", e);
  endtask

  task automatic test_backpressure();
    int e;
    e     = error_count;
    tri_i = {rand_vertex(), rand_vertex(), rand_vertex()};
    run_fragment(rand_frag(), MAX_DELAY);
    finish_test("backpressure", e);
  endtask

  initial
  begin
    clk_i           = 1'b0;
    rst_i           = 1'b1;
    frag_write_i    = 1'b0;
    frag_i          = '0;
    tri_i           = '0;
    color_depth_i   = DEPTH_32;
    fb_base_i       = 32'h0010_0000;
    fb_width_i      = 16'd640;
    mem_ack_i       = 1'b0;
    lfsr_state      = 16'd57588;
    error_count     = 0;
    test_count      = 0;
    test_fail_count = 0;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    test_reset();
    test_corners();
    test_random_32();
    test_narrow_depths();
    test_saturation();
    test_backpressure();
    $display("%0d tests run, %0d failed, %0d check errors", test_count, test_fail_count,
             error_count);
    if (error_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: sources.f
+incdir+verification
verilog/gfx_pkg.sv
verilog/gfx_bary_div.sv
verilog/gfx_cuvz.sv
verilog/gfx_fragment_writer.sv
verilog/gfx_raster_backend.sv
verification/tb_gfx_raster_backend.sv

// File: run_sim.sh
#!/bin/sh
# Build the raster back end testbench with Verilator, run it, scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f \
  --top-module tb_gfx_raster_backend -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
exit 0
